//--- hw/rob_branch_table.sv
`timescale 1ns/1ns
`include "rob_macros.svh"

module rob_branch_table (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  alloc_en,
    input  rob_pkg::rob_idx_t                     tail,
    input  logic [`ALLOC_W-1:0]                   brnc_in,
    input  logic [`ALLOC_W-1:0]                   brnc_pred,
    input  rob_pkg::brnc_cond_e [`ALLOC_W-1:0]    brnc_cond,
    input  logic [`ALLOC_W*`PC_W-1:0]             rcvr_pc_in,
    input  rob_pkg::rob_idx_t                     brnc_idx,
    input  rob_pkg::cmp_rslt_e                    brnc_cmp_rslt,
    output logic                                  mis_pred,
    output logic                                  cmt_brnc,
    output logic                                  brnc_ok,
    output logic [`PC_W-1:0]                      rcvr_pc
);

    logic [`ROB_DEPTH-1:0] brnc_flag;
    logic                  pred_q [`ROB_DEPTH];
    rob_pkg::brnc_cond_e   cond_q [`ROB_DEPTH];
    logic [`PC_W-1:0]      pc_q   [`ROB_DEPTH];
    logic                  resolve;
    logic                  taken;

    // every slot of the group rewrites its flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            brnc_flag <= '0;
        end else if (alloc_en) begin
            for (int s = 0; s < `ALLOC_W; s++) begin
                brnc_flag[rob_pkg::rob_idx_t'(tail + s)] <= brnc_in[s];
            end
        end
    end

    // branch info only kept for slots that carry a branch
    always_ff @(posedge clk) begin
        if (alloc_en) begin
            for (int s = 0; s < `ALLOC_W; s++) begin
                if (brnc_in[s]) begin
                    pred_q[rob_pkg::rob_idx_t'(tail + s)] <= brnc_pred[s];
                    cond_q[rob_pkg::rob_idx_t'(tail + s)] <= brnc_cond[s];
                    pc_q[rob_pkg::rob_idx_t'(tail + s)]   <= rcvr_pc_in[s*`PC_W +: `PC_W];
                end
            end
        end
    end

    // one resolution per cycle straight from the compare result
    assign resolve = (brnc_cmp_rslt != rob_pkg::cmp_none) && brnc_flag[brnc_idx];
    assign taken   = (2'(cond_q[brnc_idx]) == 2'(brnc_cmp_rslt));

    assign brnc_ok  = resolve && (taken == pred_q[brnc_idx]);
    assign mis_pred = resolve && (taken != pred_q[brnc_idx]);
    assign cmt_brnc = brnc_ok;

    // fetch restarts here on a wrong guess
    assign rcvr_pc = mis_pred ? pc_q[brnc_idx] : '0;

endmodule

//--- hw/rob_commit_scan.sv
`timescale 1ns/1ns
`include "rob_macros.svh"

module rob_commit_scan (
    input  rob_pkg::rob_idx_t     head,
    input  logic [`ROB_DEPTH-1:0] entry_vld,
    input  logic [`ROB_DEPTH-1:0] entry_done,
    output logic [`CNT_W-1:0]     commit_cnt
);

    logic [`COMMIT_W-1:0] ready;

    // look at the window of entries starting at head
    always_comb begin
        for (int k = 0; k < `COMMIT_W; k++) begin
            ready[k] = entry_vld[rob_pkg::rob_idx_t'(head + k)] &&
                       entry_done[rob_pkg::rob_idx_t'(head + k)];
        end
    end

    // count until the first entry that is not ready
    always_comb begin
        logic stop;
        stop       = 1'b0;
        commit_cnt = '0;
        for (int k = 0; k < `COMMIT_W; k++) begin
            if (!ready[k]) begin
                stop = 1'b1;
            end
            if (!stop) begin
                commit_cnt = commit_cnt + 1'b1;
            end
        end
    end

endmodule

//--- hw/rob_macros.svh
`ifndef ROB_MACROS_SVH
`define ROB_MACROS_SVH

// buffer geometry
`define ROB_DEPTH 16
`define ROB_IDX_W 4
// extra wrap bit tells full from empty
`define ROB_PTR_W 5

// group sizes on the allocate and retire sides
`define ALLOC_W   4
`define COMMIT_W  4
`define CNT_W     3

`define PC_W      16

`endif

//--- hw/rob_pkg.sv
`include "rob_macros.svh"

package rob_pkg;

    // condition a branch tests, encoded to line up with cmp_rslt_e
    typedef enum logic [1:0] {
        cond_eq = 2'd1,
        cond_lt = 2'd2,
        cond_gt = 2'd3
    } brnc_cond_e;

    // compare result from the register file
    typedef enum logic [1:0] {
        cmp_none = 2'd0,
        cmp_eq   = 2'd1,
        cmp_lt   = 2'd2,
        cmp_gt   = 2'd3
    } cmp_rslt_e;

    typedef logic [`ROB_IDX_W-1:0] rob_idx_t;

endpackage

//--- hw/rob_ptr_ctrl.sv
`timescale 1ns/1ns
`include "rob_macros.svh"

module rob_ptr_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              alloc_vld,
    input  logic [`CNT_W-1:0] commit_cnt,
    input  logic              mis_pred,
    input  rob_pkg::rob_idx_t brnc_idx,
    output rob_pkg::rob_idx_t head,
    output rob_pkg::rob_idx_t tail,
    output logic              alloc_en,
    output logic              rob_full,
    output logic              rob_empty
);

    logic [`ROB_PTR_W-1:0] head_ptr;
    logic [`ROB_PTR_W-1:0] tail_ptr;
    logic [`ROB_PTR_W-1:0] occupancy;
    logic [`ROB_PTR_W-1:0] rollback_ptr;
    rob_pkg::rob_idx_t     brnc_dist;

    assign head = head_ptr[`ROB_IDX_W-1:0];
    assign tail = tail_ptr[`ROB_IDX_W-1:0];

    // entries in flight, 0 up to depth
    assign occupancy = tail_ptr - head_ptr;
    // stall once a whole group no longer fits
    assign rob_full  = occupancy > `ROB_PTR_W'(`ROB_DEPTH - `ALLOC_W);
    assign rob_empty = (occupancy == '0);
    assign alloc_en  = alloc_vld && !rob_full;

    // rebuild the tail from head so the wrap bit comes out right
    assign brnc_dist    = brnc_idx - head;
    assign rollback_ptr = head_ptr + {1'b0, brnc_dist} + 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_ptr <= '0;
        end else begin
            head_ptr <= head_ptr + `ROB_PTR_W'(commit_cnt);
        end
    end

    // flush wins over a group arriving in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tail_ptr <= '0;
        end else if (mis_pred) begin
            tail_ptr <= rollback_ptr;
        end else if (alloc_en) begin
            tail_ptr <= tail_ptr + `ROB_PTR_W'(`ALLOC_W);
        end
    end

    // retire never outruns the allocated entries
    a_commit_le_occ: assert property (@(posedge clk) disable iff (!rst_n)
        `ROB_PTR_W'(commit_cnt) <= occupancy);

    // a granted group never pushes the tail past the head
    a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
        alloc_en |=> occupancy <= `ROB_PTR_W'(`ROB_DEPTH));

endmodule

//--- hw/rob_status_array.sv
`timescale 1ns/1ns
`include "rob_macros.svh"

module rob_status_array (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  alloc_en,
    input  rob_pkg::rob_idx_t     tail,
    input  rob_pkg::rob_idx_t     head,
    input  logic [`CNT_W-1:0]     commit_cnt,
    input  logic                  mis_pred,
    input  rob_pkg::rob_idx_t     brnc_idx,
    input  logic                  brnc_ok,
    input  logic                  mult_done_vld,
    input  rob_pkg::rob_idx_t     mult_done_idx,
    input  logic                  alu_done_vld,
    input  rob_pkg::rob_idx_t     alu_done_idx,
    input  logic                  ld_done_vld,
    input  rob_pkg::rob_idx_t     ld_done_idx,
    output logic [`ROB_DEPTH-1:0] entry_vld,
    output logic [`ROB_DEPTH-1:0] entry_done
);

    logic [`ROB_DEPTH-1:0] alloc_mask;
    logic [`ROB_DEPTH-1:0] clr_mask;
    logic [`ROB_DEPTH-1:0] done_mask;
    rob_pkg::rob_idx_t     brnc_dist;

    // age of the resolving branch, counted from head
    assign brnc_dist = brnc_idx - head;

    always_comb begin
        alloc_mask = '0;
        clr_mask   = '0;
        done_mask  = '0;

        // new group at tail, dropped when a flush hits
        for (int k = 0; k < `ALLOC_W; k++) begin
            if (alloc_en && !mis_pred) begin
                alloc_mask[rob_pkg::rob_idx_t'(tail + k)] = 1'b1;
            end
        end

        // retiring entries at head
        for (int k = 0; k < `COMMIT_W; k++) begin
            if (k < commit_cnt) begin
                clr_mask[rob_pkg::rob_idx_t'(head + k)] = 1'b1;
            end
        end

        for (int i = 0; i < `ROB_DEPTH; i++) begin
            // younger than the branch means further from head
            if (mis_pred && entry_vld[i] &&
                (rob_pkg::rob_idx_t'(i - head) > brnc_dist)) begin
                clr_mask[i] = 1'b1;
            end
            done_mask[i] = (mult_done_vld && (mult_done_idx == i)) ||
                           (alu_done_vld && (alu_done_idx == i)) ||
                           (ld_done_vld && (ld_done_idx == i)) ||
                           ((mis_pred || brnc_ok) && (brnc_idx == i));
        end
    end

    // clear beats set; a fresh entry starts not done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_vld  <= '0;
            entry_done <= '0;
        end else begin
            entry_vld  <= (entry_vld | alloc_mask) & ~clr_mask;
            entry_done <= (entry_done | done_mask) & ~clr_mask & ~alloc_mask;
        end
    end

    // execution units only report entries the buffer holds
    a_done_on_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (!mult_done_vld || entry_vld[mult_done_idx]) &&
        (!alu_done_vld || entry_vld[alu_done_idx]) &&
        (!ld_done_vld || entry_vld[ld_done_idx]));

endmodule

//--- hw/rob_top.sv
`timescale 1ns/1ns
`include "rob_macros.svh"

module rob_top (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               alloc_vld,
    input  logic [`ALLOC_W-1:0]                brnc_in,
    input  logic [`ALLOC_W-1:0]                brnc_pred,
    input  rob_pkg::brnc_cond_e [`ALLOC_W-1:0] brnc_cond,
    input  logic [`ALLOC_W*`PC_W-1:0]          rcvr_pc_in,
    input  logic                               mult_done_vld,
    input  rob_pkg::rob_idx_t                  mult_done_idx,
    input  logic                               alu_done_vld,
    input  rob_pkg::rob_idx_t                  alu_done_idx,
    input  logic                               ld_done_vld,
    input  rob_pkg::rob_idx_t                  ld_done_idx,
    input  rob_pkg::rob_idx_t                  brnc_idx,
    input  rob_pkg::cmp_rslt_e                 brnc_cmp_rslt,
    output rob_pkg::rob_idx_t                  next_idx,
    output logic [`CNT_W-1:0]                  commit_cnt,
    output logic                               mis_pred,
    output logic                               cmt_brnc,
    output logic [`PC_W-1:0]                   rcvr_pc,
    output logic                               rob_full,
    output logic                               rob_empty
);

    rob_pkg::rob_idx_t     head;
    rob_pkg::rob_idx_t     tail;
    logic                  alloc_en;
    logic                  brnc_ok;
    logic [`ROB_DEPTH-1:0] entry_vld;
    logic [`ROB_DEPTH-1:0] entry_done;

    // allocation hands out the current tail
    assign next_idx = tail;

    rob_ptr_ctrl u_ptr (
        .clk        (clk),
        .rst_n      (rst_n),
        .alloc_vld  (alloc_vld),
        .commit_cnt (commit_cnt),
        .mis_pred   (mis_pred),
        .brnc_idx   (brnc_idx),
        .head       (head),
        .tail       (tail),
        .alloc_en   (alloc_en),
        .rob_full   (rob_full),
        .rob_empty  (rob_empty)
    );

    rob_status_array u_status (
        .clk           (clk),
        .rst_n         (rst_n),
        .alloc_en      (alloc_en),
        .tail          (tail),
        .head          (head),
        .commit_cnt    (commit_cnt),
        .mis_pred      (mis_pred),
        .brnc_idx      (brnc_idx),
        .brnc_ok       (brnc_ok),
        .mult_done_vld (mult_done_vld),
        .mult_done_idx (mult_done_idx),
        .alu_done_vld  (alu_done_vld),
        .alu_done_idx  (alu_done_idx),
        .ld_done_vld   (ld_done_vld),
        .ld_done_idx   (ld_done_idx),
        .entry_vld     (entry_vld),
        .entry_done    (entry_done)
    );

    rob_commit_scan u_scan (
        .head       (head),
        .entry_vld  (entry_vld),
        .entry_done (entry_done),
        .commit_cnt (commit_cnt)
    );

    rob_branch_table u_brnc (
        .clk           (clk),
        .rst_n         (rst_n),
        .alloc_en      (alloc_en),
        .tail          (tail),
        .brnc_in       (brnc_in),
        .brnc_pred     (brnc_pred),
        .brnc_cond     (brnc_cond),
        .rcvr_pc_in    (rcvr_pc_in),
        .brnc_idx      (brnc_idx),
        .brnc_cmp_rslt (brnc_cmp_rslt),
        .mis_pred      (mis_pred),
        .cmt_brnc      (cmt_brnc),
        .brnc_ok       (brnc_ok),
        .rcvr_pc       (rcvr_pc)
    );

endmodule

//--- tests/rob_checker.sv
`timescale 1ns/1ns
`include "rob_macros.svh"

module rob_checker (
    input  logic                               clk,
    input  logic                               chk_en,
    input  logic [`ROB_IDX_W+`CNT_W+`PC_W+3:0] exp_row,
    input  rob_pkg::rob_idx_t                  next_idx,
    input  logic [`CNT_W-1:0]                  commit_cnt,
    input  logic                               mis_pred,
    input  logic                               cmt_brnc,
    input  logic [`PC_W-1:0]                   rcvr_pc,
    input  logic                               rob_full,
    input  logic                               rob_empty,
    output int                                 err_cnt,
    output int                                 row_cnt,
    output int                                 bad_rows
);

    rob_pkg::rob_idx_t exp_next;
    logic [`CNT_W-1:0] exp_cnt;
    logic              exp_mp;
    logic              exp_cb;
    logic [`PC_W-1:0]  exp_pc;
    logic              exp_full;
    logic              exp_empty;

    assign {exp_next, exp_cnt, exp_mp, exp_cb, exp_pc, exp_full, exp_empty} = exp_row;

    initial begin
        err_cnt  = 0;
        row_cnt  = 0;
        bad_rows = 0;
    end

    function automatic int field_mismatch(input string name,
                                          input logic [`PC_W-1:0] exp_val,
                                          input logic [`PC_W-1:0] act_val);
        if (act_val !== exp_val) begin
            $display("Error at %0t ns: row %0d %s expected 0x%0h got 0x%0h",
                     $time, row_cnt, name, exp_val, act_val);
            return 1;
        end
        return 0;
    endfunction

    // DUT registers still hold the old state at this edge
    always @(posedge clk) begin : check_row
        int bad;
        if (chk_en) begin
            bad = 0;
            bad += field_mismatch("next_idx", exp_next, next_idx);
            bad += field_mismatch("commit_cnt", exp_cnt, commit_cnt);
            bad += field_mismatch("mis_pred", exp_mp, mis_pred);
            bad += field_mismatch("cmt_brnc", exp_cb, cmt_brnc);
            bad += field_mismatch("rcvr_pc", exp_pc, rcvr_pc);
            bad += field_mismatch("rob_full", exp_full, rob_full);
            bad += field_mismatch("rob_empty", exp_empty, rob_empty);
            if (bad == 0) begin
                $display("row %0d ok", row_cnt);
            end else begin
                $display("row %0d had %0d mismatches", row_cnt, bad);
                bad_rows = bad_rows + 1;
            end
            err_cnt = err_cnt + bad;
            row_cnt = row_cnt + 1;
        end
    end

endmodule

//--- tests/rob_tb.sv
`timescale 1ns/1ns
`include "rob_macros.svh"

module rob_tb;

    // alloc, brnc_in, brnc_pred, cond, pc base, three done ports, brnc_idx, cmp
    localparam int stim_w = 1 + 4 * `ALLOC_W + `PC_W + 15 + `ROB_IDX_W + 2;
    // next_idx, commit_cnt, mis_pred, cmt_brnc, rcvr_pc, rob_full, rob_empty
    localparam int exp_w  = `ROB_IDX_W + `CNT_W + 2 + `PC_W + 2;
    // no strobes, every slot on cond_eq
    localparam logic [stim_w-1:0] idle_stim = {9'd0, 8'h55, 37'd0};

    logic                               clk;
    logic                               rst_n;
    logic                               alloc_vld;
    logic [`ALLOC_W-1:0]                brnc_in;
    logic [`ALLOC_W-1:0]                brnc_pred;
    rob_pkg::brnc_cond_e [`ALLOC_W-1:0] brnc_cond;
    logic [`ALLOC_W*`PC_W-1:0]          rcvr_pc_in;
    logic                               mult_done_vld;
    rob_pkg::rob_idx_t                  mult_done_idx;
    logic                               alu_done_vld;
    rob_pkg::rob_idx_t                  alu_done_idx;
    logic                               ld_done_vld;
    rob_pkg::rob_idx_t                  ld_done_idx;
    rob_pkg::rob_idx_t                  brnc_idx;
    rob_pkg::cmp_rslt_e                 brnc_cmp_rslt;
    rob_pkg::rob_idx_t                  next_idx;
    logic [`CNT_W-1:0]                  commit_cnt;
    logic                               mis_pred;
    logic                               cmt_brnc;
    logic [`PC_W-1:0]                   rcvr_pc;
    logic                               rob_full;
    logic                               rob_empty;

    logic                               chk_en;
    logic [exp_w-1:0]                   exp_row;
    int                                 err_cnt;
    int                                 row_cnt;
    int                                 bad_rows;
    int                                 cycle_cnt;
    int                                 cycle_limit;
    logic [stim_w-1:0]                  stim_q [$];
    logic [exp_w-1:0]                   exp_q [$];

    rob_top u_dut (.*);

    rob_checker u_chk (.*);

    task automatic add_row(
        input logic                alloc,
        input logic [`ALLOC_W-1:0] bin,
        input logic [`ALLOC_W-1:0] bpred,
        input logic [7:0]          cond,
        input logic [`PC_W-1:0]    pc,
        input logic [4:0]          mult,
        input logic [4:0]          alu,
        input logic [4:0]          ld,
        input logic [3:0]          bidx,
        input logic [1:0]          cmp,
        input logic [3:0]          nxt,
        input logic [2:0]          cnt,
        input logic                mp,
        input logic                cb,
        input logic [`PC_W-1:0]    epc,
        input logic                full,
        input logic                empty
    );
        stim_q.push_back({alloc, bin, bpred, cond, pc, mult, alu, ld, bidx, cmp});
        exp_q.push_back({nxt, cnt, mp, cb, epc, full, empty});
    endtask

    task automatic load_table();
        // done ports are {vld, idx}, 'h12 marks entry 2; cmp 0 none 1 eq 2 lt 3 gt
        // cond holds two bits per slot with slot 0 lowest; slot s pc is base + 4*s
        // al br  pr   cond  pc      mult  alu   ld    bi cm  nx cn mp cb epc   fl em
        add_row(0, 'h0, 'h0, 'h55, 'h0, 'h00, 'h00, 'h00, 0, 0, 0, 0, 0, 0, 'h0, 0, 1);
        add_row(1, 'h0, 'h0, 'h55, 'h0, 'h00, 'h00, 'h00, 0, 0, 0, 0, 0, 0, 'h0, 0, 1);
        add_row(1, 'h2, 'h2, 'h55, 'h1000, 'h00, 'h00, 'h00, 0, 0, 4, 0, 0, 0, 'h0, 0, 0);
        add_row(1, 'h2, 'h2, 'h59, 'h2000, 'h00, 'h00, 'h00, 0, 0, 8, 0, 0, 0, 'h0, 0, 0);
        add_row(1, 'h0, 'h0, 'h55, 'h0, 'h00, 'h00, 'h00, 0, 0, 12, 0, 0, 0, 'h0, 0, 0);
        // buffer full, this group is dropped
        add_row(1, 'h0, 'h0, 'h55, 'h0, 'h00, 'h00, 'h00, 0, 0, 0, 0, 0, 0, 'h0, 1, 0);
        add_row(0, 'h0, 'h0, 'h55, 'h0, 'h00, 'h00, 'h00, 0, 0, 0, 0, 0, 0, 'h0, 1, 0);
        // out of order completion, head entry last
        add_row(0, 'h0, 'h0, 'h55, 'h0, 'h12, 'h11, 'h13, 0, 0, 0, 0, 0, 0, 'h0, 1, 0);
        add_row(0, 'h0, 'h0, 'h55, 'h0, 'h14, 'h10, 'h00, 0, 0, 0, 0, 0, 0, 'h0, 1, 0);
        add_row(0, 'h0, 'h0, 'h55, 'h0, 'h00, 'h00, 'h00, 0, 0, 0, 4, 0, 0, 'h0, 1, 0);
        // entry 5 predicted taken, eq matches
        add_row(0, 'h0, 'h0, 'h55, 'h0, 'h00, 'h00, 'h00, 5, 1, 0, 1, 0, 1, 'h0, 0, 0);
        add_row(0, 'h0, 'h0, 'h55, 'h0, 'h17, 'h16, 'h1a, 0, 0, 0, 1, 0, 0, 'h0, 0, 0);
        // entry 9 tests lt, gt comes back, flush beats the group
        add_row(1, 'h0, 'h0, 'h55, 'h0, 'h00, 'h00, 'h00, 9, 3, 0, 2, 1, 0, 'h2004, 0, 0);
        add_row(0, 'h0, 'h0, 'h55, 'h0, 'h00, 'h00, 'h00, 0, 0, 10, 0, 0, 0, 'h0, 0, 0);
        add_row(0, 'h0, 'h0, 'h55, 'h0, 'h00, 'h00, 'h18, 0, 0, 10, 0, 0, 0, 'h0, 0, 0);
        add_row(0, 'h0, 'h0, 'h55, 'h0, 'h00, 'h00, 'h00, 0, 0, 10, 2, 0, 0, 'h0, 0, 0);
        add_row(0, 'h0, 'h0, 'h55, 'h0, 'h00, 'h00, 'h00, 0, 0, 10, 0, 0, 0, 'h0, 0, 1);
        // refill across the wrap, 10 up to 1
        add_row(1, 'h0, 'h0, 'h55, 'h0, 'h00, 'h00, 'h00, 0, 0, 10, 0, 0, 0, 'h0, 0, 1);
        add_row(1, 'h0, 'h0, 'h55, 'h0, 'h00, 'h00, 'h00, 0, 0, 14, 0, 0, 0, 'h0, 0, 0);
        add_row(0, 'h0, 'h0, 'h55, 'h0, 'h1a, 'h1b, 'h1c, 0, 0, 2, 0, 0, 0, 'h0, 0, 0);
        add_row(0, 'h0, 'h0, 'h55, 'h0, 'h1d, 'h10, 'h11, 0, 0, 2, 3, 0, 0, 'h0, 0, 0);
        add_row(0, 'h0, 'h0, 'h55, 'h0, 'h1e, 'h1f, 'h00, 0, 0, 2, 1, 0, 0, 'h0, 0, 0);
        add_row(0, 'h0, 'h0, 'h55, 'h0, 'h00, 'h00, 'h00, 0, 0, 2, 4, 0, 0, 'h0, 0, 0);
        add_row(0, 'h0, 'h0, 'h55, 'h0, 'h00, 'h00, 'h00, 0, 0, 2, 0, 0, 0, 'h0, 0, 1);
    endtask

    task automatic drive_stim(input logic [stim_w-1:0] stim);
        logic [2*`ALLOC_W-1:0] cond_bits;
        logic [`PC_W-1:0]      pc_base;
        logic [4:0]            mult;
        logic [4:0]            alu;
        logic [4:0]            ld;
        logic [1:0]            cmp_bits;
        {alloc_vld, brnc_in, brnc_pred, cond_bits, pc_base, mult, alu, ld, brnc_idx,
         cmp_bits} = stim;
        {mult_done_vld, mult_done_idx} = mult;
        {alu_done_vld, alu_done_idx}   = alu;
        {ld_done_vld, ld_done_idx}     = ld;
        brnc_cmp_rslt = rob_pkg::cmp_rslt_e'(cmp_bits);
        for (int s = 0; s < `ALLOC_W; s++) begin
            brnc_cond[s] = rob_pkg::brnc_cond_e'(cond_bits[2*s +: 2]);
            rcvr_pc_in[s*`PC_W +: `PC_W] = pc_base + `PC_W'(4 * s);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // limit follows the table length
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: table not finished after %0d cycles", cycle_cnt);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        load_table();
        cycle_limit = stim_q.size() + 20;
        cycle_cnt   = 0;
        chk_en      = 1'b0;
        exp_row     = '0;
        rst_n       = 1'b0;
        drive_stim(idle_stim);
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int r = 0; r < stim_q.size(); r++) begin
            drive_stim(stim_q[r]);
            exp_row = exp_q[r];
            chk_en  = 1'b1;
            @(negedge clk);
        end
        chk_en = 1'b0;
        drive_stim(idle_stim);
        @(negedge clk);
        $display("%0d rows checked, %0d rows with mismatches, %0d mismatches in all",
                 row_cnt, bad_rows, err_cnt);
        if (row_cnt != stim_q.size()) begin
            $display("checker saw %0d rows but %0d were applied", row_cnt, stim_q.size());
        end
        if (err_cnt == 0 && row_cnt == stim_q.size()) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+hw
hw/rob_pkg.sv
hw/rob_ptr_ctrl.sv
hw/rob_status_array.sv
hw/rob_commit_scan.sv
hw/rob_branch_table.sv
hw/rob_top.sv
tests/rob_checker.sv
tests/rob_tb.sv
